//--- files.f
+incdir+design
design/enigma_code_pkg.sv
design/enigma_rotor_pkg.sv
design/enigma_ctrl.sv
design/enigma_rotor_a.sv
design/enigma_rotor_b.sv
design/enigma_top.sv
verification/enigma_properties.sv
verification/enigma_checker.sv
verification/enigma_tb.sv

//--- verification/enigma_tb.sv
// ==========================================================
// Testbench: clock, reset, random sessions, DUT and checker
// ==========================================================
`timescale 1ns/1ps
`include "enigma_config.svh"

module enigma_tb;

	import enigma_code_pkg::*;

	localparam int SESSIONS       = 6;
	localparam int MAX_SYMS       = 40;
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 2500; // 6 * (128 + 40 * 3 + 10) plus reset margin
	localparam int DEPTH          = `ENIGMA_DEPTH;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_valid_2;
	crypt_mode_e crypt_mode;
	sym_t        code_in;
	logic        out_valid;
	sym_t        out_code;

	int   error_count;
	int   sym_count;
	int   cycle_count = 0;
	int   sent        = 0;
	int   received    = 0;
	sym_t tab_a [DEPTH];
	sym_t tab_b [DEPTH];

	enigma_top enigma_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.out_valid  (out_valid),
		.out_code   (out_code)
	);

	enigma_checker enigma_checker_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_valid_2  (in_valid_2),
		.crypt_mode  (crypt_mode),
		.code_in     (code_in),
		.out_valid   (out_valid),
		.out_code    (out_code),
		.error_count (error_count),
		.sym_count   (sym_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(negedge clk)
		if (out_valid)
			received++;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// ======================================================
	// Stimulus helpers, all driving on the falling edge
	// ======================================================
	function automatic crypt_mode_e random_mode();
		return crypt_mode_e'($urandom_range(1, 0));
	endfunction

	task automatic drive_cycle(input logic v, input logic v2, input sym_t d, input crypt_mode_e m);
		@(negedge clk);
		in_valid   = v;
		in_valid_2 = v2;
		code_in    = d;
		crypt_mode = m;
	endtask

	task automatic shuffle_table(output sym_t tab [DEPTH]);
		int   j;
		sym_t tmp;
		for (int i = 0; i < DEPTH; i++)
			tab[i] = sym_t'(i);
		for (int i = DEPTH - 1; i > 0; i--) begin
			j      = $urandom_range(i, 0);
			tmp    = tab[i];
			tab[i] = tab[j];
			tab[j] = tmp;
		end
	endtask

	// Mode only on the first cycle, noise afterwards
	task automatic load_rotors(input crypt_mode_e m);
		for (int i = 0; i < `ENIGMA_LOAD_LEN; i++)
			drive_cycle(1'b1, 1'b0, (i < DEPTH) ? tab_a[i] : tab_b[i - DEPTH],
				(i == 0) ? m : random_mode());
	endtask

	initial begin
		int          nsym;
		int          gap;
		int          total;
		crypt_mode_e m;
		in_valid   = 1'b0;
		in_valid_2 = 1'b0;
		crypt_mode = MODE_ENCRYPT;
		code_in    = '0;
		rst_n      = 1'b0;
		void'($urandom(32'h757d_8d62));
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk); // Idle outputs checked here too
		for (int s = 0; s < SESSIONS; s++) begin
			shuffle_table(tab_a);
			shuffle_table(tab_b);
			m = random_mode();
			load_rotors(m);
			nsym = $urandom_range(MAX_SYMS, 1);
			for (int k = 0; k < nsym; k++) begin
				drive_cycle(1'b0, 1'b1, sym_t'($urandom_range(DEPTH - 1, 0)), random_mode());
				sent++;
				gap = $urandom_range(2, 0);
				repeat (gap) drive_cycle(1'b0, 1'b0, '0, random_mode());
			end
			drive_cycle(1'b0, 1'b0, '0, MODE_ENCRYPT);
			while (received < sent) @(negedge clk); // Drain before the next load
		end
		repeat (3) @(negedge clk);
		total = error_count + enigma_top_i.enigma_ctrl_i.enigma_properties_i.fail_count;
		if (sym_count != sent) begin
			$display("Checker compared %0d outputs but %0d symbols were sent", sym_count, sent);
			total++;
		end
		$display("Symbols %0d, checker errors %0d, assertion failures %0d, total errors %0d",
			sent, error_count, enigma_top_i.enigma_ctrl_i.enigma_properties_i.fail_count, total);
		if (total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- verification/enigma_checker.sv
// ==========================================================
// Reference model of the rotor cipher and output comparison
// ==========================================================
`timescale 1ns/1ps
`include "enigma_config.svh"

module enigma_checker
	import enigma_code_pkg::*;
	import enigma_rotor_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic        in_valid_2,
	input  crypt_mode_e crypt_mode,
	input  sym_t        code_in,
	input  logic        out_valid,
	input  sym_t        out_code,
	output int          error_count,
	output int          sym_count
);

	localparam int DEPTH = `ENIGMA_DEPTH;
	localparam int GROUP = `ENIGMA_GROUP;

	// Source slot in a group for each pattern and destination
	localparam int PERM_SRC [8][8] = '{
		'{0, 1, 2, 3, 4, 5, 6, 7},
		'{1, 0, 3, 2, 5, 4, 7, 6},
		'{2, 3, 0, 1, 6, 7, 4, 5},
		'{0, 4, 5, 6, 1, 2, 3, 7},
		'{4, 5, 6, 7, 0, 1, 2, 3},
		'{5, 6, 7, 3, 4, 0, 1, 2},
		'{6, 7, 3, 2, 5, 4, 0, 1},
		'{7, 6, 5, 4, 3, 2, 1, 0}
	};

	sym_t        tab_a [DEPTH];
	sym_t        tab_b [DEPTH];
	crypt_mode_e model_mode = MODE_ENCRYPT;
	int          load_idx   = 0;
	int          session    = 0;
	int          sym_idx    = 0;
	int          cyc        = 0; // Rising edges seen so far
	int          errs       = 0;
	int          syms       = 0;
	int          due_q [$];
	sym_t        val_q [$];
	string       name_q [$];

	assign error_count = errs;
	assign sym_count   = syms;

	function automatic sym_t find_entry(sym_t tab [DEPTH], sym_t v);
		sym_t pos;
		pos = '0;
		for (int i = 0; i < DEPTH; i++)
			if (tab[i] == v)
				pos = sym_t'(i);
		return pos;
	endfunction

	// ======================================================
	// Model of one symbol: lookups, then stepping
	// ======================================================
	task automatic process_symbol(input sym_t s);
		sym_t f_a;
		sym_t f_b;
		sym_t refl;
		sym_t i_b;
		int   rot;
		int   pat;
		sym_t nxt [DEPTH];
		f_a  = tab_a[s];
		f_b  = tab_b[f_a];
		refl = sym_t'(DEPTH - 1 - int'(f_b));
		i_b  = find_entry(tab_b, refl);
		due_q.push_back(cyc + 1); // Visible after the next edge
		val_q.push_back(find_entry(tab_a, i_b));
		name_q.push_back($sformatf("session %0d %s symbol %0d", session,
			model_mode == MODE_DECRYPT ? "decrypt" : "encrypt", sym_idx));
		sym_idx++;
		rot = (model_mode == MODE_DECRYPT) ? int'(i_b[1:0]) : int'(f_a[1:0]);
		pat = (model_mode == MODE_DECRYPT) ? int'(refl[2:0]) : int'(f_b[2:0]);
		for (int i = 0; i < DEPTH; i++)
			nxt[i] = tab_a[(i - rot + DEPTH) % DEPTH]; // Right rotation
		tab_a = nxt;
		for (int g = 0; g < DEPTH / GROUP; g++)
			for (int d = 0; d < GROUP; d++)
				nxt[g*GROUP + d] = tab_b[g*GROUP + PERM_SRC[pat][d]];
		tab_b = nxt;
	endtask

	always @(posedge clk) begin
		cyc++;
		if (!rst_n) begin
			load_idx = 0;
			due_q.delete();
			val_q.delete();
			name_q.delete();
		end else begin
			if (in_valid) begin
				if (load_idx == 0) begin
					model_mode = crypt_mode; // Only the first load cycle counts
					session++;
					sym_idx = 0;
				end
				if (load_idx < DEPTH)
					tab_a[load_idx] = code_in;
				else
					tab_b[load_idx - DEPTH] = code_in;
				load_idx = (load_idx + 1) % `ENIGMA_LOAD_LEN;
			end else begin
				load_idx = 0;
			end
			if (in_valid_2)
				process_symbol(code_in);
		end
	end

	// ======================================================
	// Compare on the falling edge, outputs are settled there
	// ======================================================
	always @(negedge clk) begin
		if (due_q.size() > 0 && due_q[0] == cyc) begin
			if (out_valid !== 1'b1) begin
				$display("Missing output pulse for %s", name_q[0]);
				errs++;
			end else if (out_code !== val_q[0]) begin
				$display("[ERROR] %s: expected %0d, actual %0d", name_q[0], val_q[0], out_code);
				errs++;
			end
			syms++;
			void'(due_q.pop_front());
			void'(val_q.pop_front());
			void'(name_q.pop_front());
		end else if (cyc > 0 && (out_valid !== 1'b0 || out_code !== '0)) begin
			// Registers hold no value before the first rising edge
			$display("[ERROR] idle output: expected valid 0 code 0, actual valid %b code %0d",
				out_valid, out_code);
			errs++;
		end
	end

endmodule

//--- verification/enigma_properties.sv
// ==========================================================
// Handshake timing assertions, bound to the sequencer
// ==========================================================
`timescale 1ns/1ps

module enigma_properties (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_valid_2,
	input logic out_valid
);

	int fail_count = 0; // Read by the testbench at the end

	// Load and symbol strobes never overlap
	a_inputs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_valid && in_valid_2))
	else begin
		fail_count++;
		$error("in_valid and in_valid_2 high in the same cycle");
	end

	// Symbol stage then output register, pulse two edges after the sample
	a_out_follows: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid_2 |-> ##2 out_valid)
	else begin
		fail_count++;
		$error("out_valid missing two cycles after in_valid_2");
	end

	// One output pulse per symbol, none otherwise
	a_no_extra_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid_2, 2))
	else begin
		fail_count++;
		$error("out_valid high without a symbol two cycles earlier");
	end

endmodule

bind enigma_ctrl enigma_properties enigma_properties_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_valid_2 (in_valid_2),
	.out_valid  (out_valid)
);

//--- design/enigma_top.sv
// ==========================================================
// Cipher engine top: sequencer and the two rotors
// ==========================================================
`timescale 1ns/1ps

module enigma_top
	import enigma_code_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic        in_valid_2,
	input  crypt_mode_e crypt_mode,
	input  sym_t        code_in,
	output logic        out_valid,
	output sym_t        out_code
);

	logic        shift_en;
	logic        step_en;
	sym_t        load_sym;
	sym_t        sym;
	crypt_mode_e mode;
	sym_t        spill;    // B entry 0 into A entry 63
	sym_t        a_fwd;
	sym_t        a_inv;
	sym_t        b_inv;

	enigma_ctrl enigma_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.a_inv      (a_inv),
		.shift_en   (shift_en),
		.step_en    (step_en),
		.load_sym   (load_sym),
		.sym        (sym),
		.mode       (mode),
		.out_valid  (out_valid),
		.out_code   (out_code)
	);

	// ======================================================
	// Rotors
	// ======================================================
	enigma_rotor_a enigma_rotor_a_i (
		.clk      (clk),
		.shift_en (shift_en),
		.step_en  (step_en),
		.shift_in (spill),
		.sym      (sym),
		.b_inv    (b_inv),
		.mode     (mode),
		.a_fwd    (a_fwd),
		.a_inv    (a_inv)
	);

	enigma_rotor_b enigma_rotor_b_i (
		.clk      (clk),
		.shift_en (shift_en),
		.step_en  (step_en),
		.load_sym (load_sym),
		.a_fwd    (a_fwd),
		.mode     (mode),
		.spill    (spill),
		.b_inv    (b_inv)
	);

endmodule

//--- design/enigma_rotor_b.sv
// ==========================================================
// Rotor B: table storage, lookups, reflector, group permutation
// ==========================================================
`timescale 1ns/1ps
`include "enigma_config.svh"

module enigma_rotor_b
	import enigma_code_pkg::*;
	import enigma_rotor_pkg::*;
(
	input  logic        clk,
	input  logic        shift_en,
	input  logic        step_en,
	input  sym_t        load_sym,
	input  sym_t        a_fwd,
	input  crypt_mode_e mode,
	output sym_t        spill,
	output sym_t        b_inv
);

	localparam int NGROUP = `ENIGMA_DEPTH / `ENIGMA_GROUP;

	rotor_t  rot_b;
	rotor_t  rot_next;
	sym_t    b_fwd;
	sym_t    b_refl;
	b_step_t b_step;

	// Entry 0 leaves B toward the top of A during a load
	assign spill = rot_b[0];

	// ======================================================
	// Forward, reflector, inverse
	// ======================================================
	assign b_fwd  = rot_b[a_fwd];
	assign b_refl = sym_t'(`ENIGMA_DEPTH - 1) - b_fwd; // 63 - value
	assign b_inv  = rotor_index(rot_b, b_refl);

	// ======================================================
	// Group permutation
	// ======================================================
	always_comb begin
		if (mode == MODE_DECRYPT)
			b_step = b_refl[2:0];
		else
			b_step = b_fwd[2:0];
	end

	// Same pattern in every group of 8
	always_comb begin
		for (int g = 0; g < NGROUP; g++) begin
			for (int d = 0; d < `ENIGMA_GROUP; d++) begin
				rot_next[g*`ENIGMA_GROUP + d] =
					rot_b[g*`ENIGMA_GROUP + int'(B_PERM[b_step][d])];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift_en)
			rot_b <= {load_sym, rot_b[`ENIGMA_DEPTH-1:1]}; // New symbol at the top
		else if (step_en)
			rot_b <= rot_next;
	end

endmodule

//--- design/enigma_rotor_a.sv
// ==========================================================
// Rotor A: table storage, forward and inverse lookup, rotation
// ==========================================================
`timescale 1ns/1ps
`include "enigma_config.svh"

module enigma_rotor_a
	import enigma_code_pkg::*;
	import enigma_rotor_pkg::*;
(
	input  logic        clk,
	input  logic        shift_en,
	input  logic        step_en,
	input  sym_t        shift_in,
	input  sym_t        sym,
	input  sym_t        b_inv,
	input  crypt_mode_e mode,
	output sym_t        a_fwd,
	output sym_t        a_inv
);

	rotor_t  rot_a;
	a_step_t a_step;
	rotor_t  rot_next;

	// ======================================================
	// Lookups
	// ======================================================
	assign a_fwd = rot_a[sym];

	// Last pass of the symbol, back out through A
	assign a_inv = rotor_index(rot_a, b_inv);

	// ======================================================
	// Stepping
	// ======================================================
	// Encrypt steps on the forward value, decrypt on the inverse
	// one, so both directions see the same rotation sequence
	always_comb begin
		if (mode == MODE_DECRYPT)
			a_step = b_inv[1:0];
		else
			a_step = a_fwd[1:0];
	end

	// Rotate right, entry i takes entry i - step, wrapping
	always_comb begin
		for (int i = 0; i < `ENIGMA_DEPTH; i++) begin
			rot_next[i] = rot_a[sym_t'(i - int'(a_step))];
		end
	end

	always_ff @(posedge clk) begin
		if (shift_en)
			rot_a <= {shift_in, rot_a[`ENIGMA_DEPTH-1:1]}; // Fed from B entry 0
		else if (step_en)
			rot_a <= rot_next;
	end

endmodule

//--- design/enigma_ctrl.sv
// ==========================================================
// Load sequencing, mode capture, symbol stage and output register
// ==========================================================
`timescale 1ns/1ps
`include "enigma_config.svh"

module enigma_ctrl
	import enigma_code_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic        in_valid_2,
	input  crypt_mode_e crypt_mode,
	input  sym_t        code_in,
	input  sym_t        a_inv,
	output logic        shift_en,
	output logic        step_en,
	output sym_t        load_sym,
	output sym_t        sym,
	output crypt_mode_e mode,
	output logic        out_valid,
	output sym_t        out_code
);

	localparam int CNT_W     = $clog2(`ENIGMA_LOAD_LEN);
	localparam int LOAD_LAST = `ENIGMA_LOAD_LEN - 1;

	logic             load_phase; // Inside a load session
	logic [CNT_W-1:0] load_cnt;

	// ======================================================
	// Load side
	// ======================================================
	assign shift_en = in_valid; // Rotors shift on every load cycle
	assign load_sym = code_in;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_phase <= 1'b0;
			load_cnt   <= '0;
			mode       <= MODE_ENCRYPT;
		end else if (in_valid) begin
			if (!load_phase)
				mode <= crypt_mode; // First symbol of a load
			if (load_cnt == CNT_W'(LOAD_LAST)) begin
				load_phase <= 1'b0;
				load_cnt   <= '0;
			end else begin
				load_phase <= 1'b1;
				load_cnt   <= load_cnt + 1'b1;
			end
		end else begin
			// Dropped load, next one starts from zero
			load_phase <= 1'b0;
			load_cnt   <= '0;
		end
	end

	// ======================================================
	// Symbol stage and output register
	// ======================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			step_en <= 1'b0;
		else
			step_en <= in_valid_2;
	end

	always_ff @(posedge clk) begin
		if (in_valid_2)
			sym <= code_in;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_code  <= '0;
		end else begin
			out_valid <= step_en;
			out_code  <= step_en ? a_inv : '0; // Held at 0 when idle
		end
	end

endmodule

//--- design/enigma_rotor_pkg.sv
// ==========================================================
// Rotor table and step types, rotor B group permutations,
// inverse table search
// ==========================================================
`include "enigma_config.svh"

package enigma_rotor_pkg;

	import enigma_code_pkg::*;

	// Whole rotor, entry i at rot[i]
	typedef sym_t [`ENIGMA_DEPTH-1:0] rotor_t;

	typedef logic [1:0] a_step_t; // Right rotation of A, 0..3 places
	typedef logic [2:0] b_step_t; // Group pattern for B

	// ======================================================
	// Source position inside a group, per pattern and destination
	// ======================================================
	localparam logic [2:0] B_PERM [2**$bits(b_step_t)][`ENIGMA_GROUP] = '{
		'{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7}, // Hold
		'{3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6}, // Swap pairs
		'{3'd2, 3'd3, 3'd0, 3'd1, 3'd6, 3'd7, 3'd4, 3'd5}, // Swap pairs of pairs
		'{3'd0, 3'd4, 3'd5, 3'd6, 3'd1, 3'd2, 3'd3, 3'd7},
		'{3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1, 3'd2, 3'd3}, // Swap halves
		'{3'd5, 3'd6, 3'd7, 3'd3, 3'd4, 3'd0, 3'd1, 3'd2},
		'{3'd6, 3'd7, 3'd3, 3'd2, 3'd5, 3'd4, 3'd0, 3'd1},
		'{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0}  // Reverse
	};

	// Position of val in the table, tables hold a permutation
	function automatic sym_t rotor_index(rotor_t tbl, sym_t val);
		sym_t idx;
		idx = '0;
		for (int i = 0; i < `ENIGMA_DEPTH; i++) begin
			if (tbl[i] == val)
				idx = sym_t'(i);
		end
		return idx;
	endfunction

endpackage

//--- design/enigma_code_pkg.sv
// ==========================================================
// Symbol and cipher direction types
// ==========================================================
`include "enigma_config.svh"

package enigma_code_pkg;

	// One cipher symbol, also a rotor address
	typedef logic [`ENIGMA_SYM_W-1:0] sym_t;

	// Direction latched at the start of a load
	typedef enum logic {
		MODE_ENCRYPT = 1'b0,
		MODE_DECRYPT = 1'b1
	} crypt_mode_e;

endpackage

//--- design/enigma_config.svh
// ==========================================================
// Build constants for the rotor cipher engine
// ==========================================================
`ifndef ENIGMA_CONFIG_SVH
`define ENIGMA_CONFIG_SVH

// Bits per symbol
`define ENIGMA_SYM_W 6

// Entries in each rotor, one per symbol value
`define ENIGMA_DEPTH 64

// Rotor B permutes in groups of this many entries
`define ENIGMA_GROUP 8

// One load session fills rotor A, then rotor B
`define ENIGMA_LOAD_LEN 128

`endif
